//--- logic/exec_pkg.sv
package exec_pkg;

    // data width, fixed by the word-mode and immediate rules
    localparam int xlen = 64;

    // operand or result word
    typedef logic [xlen-1:0] word_t;

    // shift amount covers the full 64-bit range
    typedef logic [5:0] shamt_t;

    // raw immediate field
    typedef logic [15:0] imm_t;

    // micro-ops handed in by the decode stage
    typedef enum logic [3:0] {
        op_add  = 4'd0,
        op_sub  = 4'd1,
        op_and  = 4'd2,
        op_or   = 4'd3,
        op_xor  = 4'd4,
        op_nor  = 4'd5,
        op_slt  = 4'd6,
        op_sltu = 4'd7,
        op_sll  = 4'd8,
        op_srl  = 4'd9,
        op_sra  = 4'd10,
        op_lui  = 4'd11
    } op_t;

    // operand sources
    // ex is the stage's own registered result, mem comes from the next stage
    typedef enum logic [1:0] {
        fwd_reg = 2'd0,
        fwd_ex  = 2'd1,
        fwd_mem = 2'd2
    } fwd_t;

endpackage

//--- logic/exec_control.sv
`timescale 1ns/100ps

module exec_control (
    input  logic            clock,
    input  logic            reset,
    input  logic            req,
    output logic            ack,
    input  exec_pkg::fwd_t  fwd_a,
    input  exec_pkg::fwd_t  fwd_b,
    input  exec_pkg::word_t reg_a,
    input  exec_pkg::word_t reg_b,
    input  exec_pkg::word_t mem_data,
    output exec_pkg::word_t opnd_a,
    output exec_pkg::word_t opnd_b,
    input  exec_pkg::word_t next_result,
    input  logic            next_overflow,
    output exec_pkg::word_t result,
    output logic            overflow
);

    // four-phase handshake, one operation in flight
    typedef enum logic {
        st_idle,
        st_done
    } state_t;

    state_t state;
    state_t state_next;
    logic   accept;

    // operand source mux
    function automatic exec_pkg::word_t forward(
        input exec_pkg::fwd_t  sel,
        input exec_pkg::word_t reg_value,
        input exec_pkg::word_t ex_value,
        input exec_pkg::word_t mem_value
    );
        exec_pkg::word_t value;
        case (sel)
            exec_pkg::fwd_ex: begin
                value = ex_value;
            end
            exec_pkg::fwd_mem: begin
                value = mem_value;
            end
            default: begin
                value = reg_value;
            end
        endcase
        return value;
    endfunction

    // operands go straight to the datapath, no register in between
    assign opnd_a = forward(fwd_a, reg_a, result, mem_data);
    assign opnd_b = forward(fwd_b, reg_b, result, mem_data);

    // a request is taken only from idle
    assign accept = (state == st_idle) && req;

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (req) begin
                    state_next = st_done;
                end
            end
            st_done: begin
                // hold the result until the requester lets go
                if (!req) begin
                    state_next = st_idle;
                end
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    // ack follows the state register directly
    assign ack = (state == st_done);

    // result register doubles as the fwd_ex source
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            result   <= '0;
            overflow <= 1'b0;
        end else if (accept) begin
            result   <= next_result;
            overflow <= next_overflow;
        end
    end

endmodule

//--- logic/arith_unit.sv
`timescale 1ns/100ps

module arith_unit (
    input  exec_pkg::word_t opnd_a,
    input  exec_pkg::word_t opnd_b,
    input  exec_pkg::op_t   op,
    output exec_pkg::word_t sum_out,
    output logic            overflow_out,
    output logic            lt_signed,
    output logic            lt_unsigned
);

    logic            subtract;
    exec_pkg::word_t b_eff;
    logic            carry_out;
    logic            sign_a;
    logic            sign_b;
    logic            sign_sum;

    // compares run through the subtractor as well
    assign subtract = (op == exec_pkg::op_sub)
                   || (op == exec_pkg::op_slt)
                   || (op == exec_pkg::op_sltu);

    // a - b as a + ~b + 1
    assign b_eff = subtract ? ~opnd_b : opnd_b;
    assign {carry_out, sum_out} = {1'b0, opnd_a} + {1'b0, b_eff}
                                + {{exec_pkg::xlen{1'b0}}, subtract};

    assign sign_a   = opnd_a[exec_pkg::xlen-1];
    assign sign_b   = opnd_b[exec_pkg::xlen-1];
    assign sign_sum = sum_out[exec_pkg::xlen-1];

    // same effective signs in, different sign out
    assign overflow_out = (sign_a == b_eff[exec_pkg::xlen-1]) && (sign_sum != sign_a);

    // no carry out of a subtract means a borrow
    assign lt_unsigned = ~carry_out;

    // with different signs the negative operand is the smaller one
    assign lt_signed = (sign_a != sign_b) ? sign_a : sign_sum;

endmodule

//--- logic/logic_unit.sv
`timescale 1ns/100ps

module logic_unit (
    input  exec_pkg::word_t opnd_a,
    input  exec_pkg::word_t opnd_b,
    input  exec_pkg::op_t   op,
    output exec_pkg::word_t logic_out
);

    // bitwise ops, anything else reads as zero
    always_comb begin
        case (op)
            exec_pkg::op_and: begin
                logic_out = opnd_a & opnd_b;
            end
            exec_pkg::op_or: begin
                logic_out = opnd_a | opnd_b;
            end
            exec_pkg::op_xor: begin
                logic_out = opnd_a ^ opnd_b;
            end
            exec_pkg::op_nor: begin
                logic_out = ~(opnd_a | opnd_b);
            end
            default: begin
                logic_out = '0;
            end
        endcase
    end

endmodule

//--- logic/shift_unit.sv
`timescale 1ns/100ps

module shift_unit (
    input  exec_pkg::word_t  opnd_b,
    input  exec_pkg::shamt_t shamt,
    input  exec_pkg::op_t    op,
    input  logic             word,
    output exec_pkg::word_t  shift_out
);

    logic             shift_left;
    logic             fill;
    exec_pkg::shamt_t amount;
    exec_pkg::word_t  stage [0:6];

    assign shift_left = (op == exec_pkg::op_sll);

    // fill bit for right shifts
    // word mode takes the sign from bit 31
    always_comb begin
        fill = 1'b0;
        if (op == exec_pkg::op_sra) begin
            fill = word ? opnd_b[31] : opnd_b[exec_pkg::xlen-1];
        end
    end

    // word mode works on the low half, extended so right shifts pull in the right bits
    assign stage[0] = word ? {{32{fill}}, opnd_b[31:0]} : opnd_b;
    assign amount   = word ? {1'b0, shamt[4:0]} : shamt;

    // one level per amount bit, 1 through 32
    for (genvar i = 0; i < 6; i++) begin : g_level
        localparam int step = 1 << i;

        exec_pkg::word_t shifted;

        assign shifted = shift_left
            ? {stage[i][exec_pkg::xlen-1-step:0], {step{1'b0}}}
            : {{step{fill}}, stage[i][exec_pkg::xlen-1:step]};
        assign stage[i+1] = amount[i] ? shifted : stage[i];
    end

    // upper half in word mode is fixed up by result_select
    assign shift_out = stage[6];

endmodule

//--- logic/result_select.sv
`timescale 1ns/100ps

module result_select (
    input  exec_pkg::op_t   op,
    input  logic            word,
    input  exec_pkg::imm_t  imm,
    input  exec_pkg::word_t opnd_a,
    input  exec_pkg::word_t opnd_b,
    input  exec_pkg::word_t sum_out,
    input  exec_pkg::word_t logic_out,
    input  exec_pkg::word_t shift_out,
    input  logic            overflow_out,
    input  logic            lt_signed,
    input  logic            lt_unsigned,
    output exec_pkg::word_t next_result,
    output logic            next_overflow
);

    logic            is_addsub;
    logic            b_sign_eff;
    logic            overflow_32;
    exec_pkg::word_t sum_sel;
    exec_pkg::word_t shift_sel;
    exec_pkg::word_t lui_value;

    assign is_addsub = (op == exec_pkg::op_add) || (op == exec_pkg::op_sub);

    // 32-bit overflow from bit 31
    // subtract flips the sign of b
    assign b_sign_eff  = (op == exec_pkg::op_sub) ? ~opnd_b[31] : opnd_b[31];
    assign overflow_32 = (opnd_a[31] == b_sign_eff) && (sum_out[31] != opnd_a[31]);

    // word results sign-extended from bit 31
    assign sum_sel   = word ? {{32{sum_out[31]}}, sum_out[31:0]} : sum_out;
    assign shift_sel = word ? {{32{shift_out[31]}}, shift_out[31:0]} : shift_out;

    // sign-extended immediate moved up by 16
    assign lui_value = {{32{imm[15]}}, imm, 16'b0};

    always_comb begin
        case (op)
            exec_pkg::op_add,
            exec_pkg::op_sub: begin
                next_result = sum_sel;
            end
            exec_pkg::op_slt: begin
                next_result = {{(exec_pkg::xlen-1){1'b0}}, lt_signed};
            end
            exec_pkg::op_sltu: begin
                next_result = {{(exec_pkg::xlen-1){1'b0}}, lt_unsigned};
            end
            exec_pkg::op_sll,
            exec_pkg::op_srl,
            exec_pkg::op_sra: begin
                next_result = shift_sel;
            end
            exec_pkg::op_lui: begin
                next_result = lui_value;
            end
            default: begin
                next_result = logic_out;
            end
        endcase
    end

    // only add and sub can raise the flag
    assign next_overflow = is_addsub && (word ? overflow_32 : overflow_out);

endmodule

//--- logic/exec_unit.sv
`timescale 1ns/100ps

module exec_unit (
    input  logic             clock,
    input  logic             reset,
    input  logic             req,
    output logic             ack,
    input  exec_pkg::op_t    op,
    input  logic             word,
    input  exec_pkg::fwd_t   fwd_a,
    input  exec_pkg::fwd_t   fwd_b,
    input  exec_pkg::word_t  reg_a,
    input  exec_pkg::word_t  reg_b,
    input  exec_pkg::word_t  mem_data,
    input  exec_pkg::shamt_t shamt,
    input  exec_pkg::imm_t   imm,
    output exec_pkg::word_t  result,
    output logic             overflow
);

    exec_pkg::word_t opnd_a;
    exec_pkg::word_t opnd_b;
    exec_pkg::word_t sum_out;
    exec_pkg::word_t logic_out;
    exec_pkg::word_t shift_out;
    exec_pkg::word_t next_result;
    logic            overflow_out;
    logic            lt_signed;
    logic            lt_unsigned;
    logic            next_overflow;

    exec_control u_control (
        .clock         (clock),
        .reset         (reset),
        .req           (req),
        .ack           (ack),
        .fwd_a         (fwd_a),
        .fwd_b         (fwd_b),
        .reg_a         (reg_a),
        .reg_b         (reg_b),
        .mem_data      (mem_data),
        .opnd_a        (opnd_a),
        .opnd_b        (opnd_b),
        .next_result   (next_result),
        .next_overflow (next_overflow),
        .result        (result),
        .overflow      (overflow)
    );

    arith_unit u_arith (
        .opnd_a       (opnd_a),
        .opnd_b       (opnd_b),
        .op           (op),
        .sum_out      (sum_out),
        .overflow_out (overflow_out),
        .lt_signed    (lt_signed),
        .lt_unsigned  (lt_unsigned)
    );

    logic_unit u_logic (
        .opnd_a    (opnd_a),
        .opnd_b    (opnd_b),
        .op        (op),
        .logic_out (logic_out)
    );

    // shifts act on operand b only
    shift_unit u_shift (
        .opnd_b    (opnd_b),
        .shamt     (shamt),
        .op        (op),
        .word      (word),
        .shift_out (shift_out)
    );

    result_select u_select (
        .op            (op),
        .word          (word),
        .imm           (imm),
        .opnd_a        (opnd_a),
        .opnd_b        (opnd_b),
        .sum_out       (sum_out),
        .logic_out     (logic_out),
        .shift_out     (shift_out),
        .overflow_out  (overflow_out),
        .lt_signed     (lt_signed),
        .lt_unsigned   (lt_unsigned),
        .next_result   (next_result),
        .next_overflow (next_overflow)
    );

endmodule

//--- dv/clock_gen.sv
`timescale 1ns/100ps

module clock_gen (
    output logic clock,
    output logic reset
);

    // 100 ns period
    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // three rising edges in reset, released away from the sampling edge
    initial begin
        reset = 1'b1;
        repeat (3) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
    end

endmodule

//--- dv/exec_unit_chk.sv
`timescale 1ns/100ps

module exec_unit_chk (
    input logic            clock,
    input logic            reset,
    input logic            req,
    input logic            ack,
    input exec_pkg::word_t result,
    input logic            overflow
);

    int unsigned error_count = 0;

    // ack only rises for a request seen at the edge before
    a_ack_needs_req: assert property (@(posedge clock) disable iff (reset)
        $rose(ack) |-> $past(req))
        else begin
            $error("ack rose without a request");
            error_count++;
        end

    // result held while the requester has not let go
    a_result_held: assert property (@(posedge clock) disable iff (reset)
        ack && $past(ack) |-> $stable(result) && $stable(overflow))
        else begin
            $error("result or overflow changed while ack was high");
            error_count++;
        end

    a_idle_after_reset: assert property (@(posedge clock)
        $fell(reset) |-> !ack)
        else begin
            $error("ack high in the cycle after reset");
            error_count++;
        end

    // four-phase release
    a_ack_drops: assert property (@(posedge clock) disable iff (reset)
        ack && !req |=> !ack)
        else begin
            $error("ack still high one cycle after req dropped");
            error_count++;
        end

endmodule

//--- dv/exec_unit_tb.sv
`timescale 1ns/100ps

module exec_unit_tb;

    // short names for the operand sources in the table
    localparam exec_pkg::fwd_t fr = exec_pkg::fwd_reg;
    localparam exec_pkg::fwd_t fe = exec_pkg::fwd_ex;
    localparam exec_pkg::fwd_t fm = exec_pkg::fwd_mem;

    typedef struct {
        string            name;
        exec_pkg::op_t    op;
        logic             word;
        exec_pkg::fwd_t   fwd_a;
        exec_pkg::fwd_t   fwd_b;
        exec_pkg::word_t  reg_a;
        exec_pkg::word_t  reg_b;
        exec_pkg::word_t  mem_data;
        exec_pkg::shamt_t shamt;
        exec_pkg::imm_t   imm;
        exec_pkg::word_t  exp_result;
        logic             exp_overflow;
    } test_t;

    logic             clock;
    logic             reset;
    logic             req;
    logic             ack;
    exec_pkg::op_t    op;
    logic             word;
    exec_pkg::fwd_t   fwd_a;
    exec_pkg::fwd_t   fwd_b;
    exec_pkg::word_t  reg_a;
    exec_pkg::word_t  reg_b;
    exec_pkg::word_t  mem_data;
    exec_pkg::shamt_t shamt;
    exec_pkg::imm_t   imm;
    exec_pkg::word_t  result;
    logic             overflow;

    test_t           tests[$];
    exec_pkg::word_t rng_state;
    int              errors;
    int              passed;

    clock_gen u_clock (
        .clock (clock),
        .reset (reset)
    );

    exec_unit u_exec_unit (.*);

    bind exec_unit exec_unit_chk u_chk (.*);

    // xorshift64 step
    function automatic exec_pkg::word_t next_random();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 7;
        rng_state ^= rng_state << 17;
        return rng_state;
    endfunction

    function automatic exec_pkg::word_t sext32(logic [31:0] value);
        return {{32{value[31]}}, value};
    endfunction

    function automatic exec_pkg::word_t source_operand(exec_pkg::fwd_t sel,
            exec_pkg::word_t reg_value, exec_pkg::word_t prev, exec_pkg::word_t mem_value);
        return (sel == fe) ? prev : ((sel == fm) ? mem_value : reg_value);
    endfunction

    // expected result from the forwarded operands
    function automatic exec_pkg::word_t model_result(test_t t, exec_pkg::word_t a,
            exec_pkg::word_t b);
        int unsigned     amount;
        exec_pkg::word_t r;
        amount = t.word ? t.shamt % 32 : t.shamt;
        case (t.op)
            exec_pkg::op_add:  r = a + b;
            exec_pkg::op_sub:  r = a - b;
            exec_pkg::op_and:  r = a & b;
            exec_pkg::op_or:   r = a | b;
            exec_pkg::op_xor:  r = a ^ b;
            exec_pkg::op_nor:  r = ~(a | b);
            exec_pkg::op_slt:  r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            exec_pkg::op_sltu: r = (a < b) ? 64'd1 : 64'd0;
            exec_pkg::op_sll:  r = t.word ? sext32(b[31:0] << amount) : b << amount;
            exec_pkg::op_srl:  r = t.word ? sext32(b[31:0] >> amount) : b >> amount;
            exec_pkg::op_sra: begin
                if (t.word) begin
                    r = sext32($signed(b[31:0]) >>> amount);
                end else begin
                    r = $signed(b) >>> amount;
                end
            end
            exec_pkg::op_lui:  r = {{48{t.imm[15]}}, t.imm} << 16;
            default:           r = '0;
        endcase
        if (t.word && (t.op == exec_pkg::op_add || t.op == exec_pkg::op_sub)) begin
            r = sext32(r[31:0]);
        end
        return r;
    endfunction

    // signed overflow through one guard bit above the sign
    function automatic logic model_overflow(test_t t, exec_pkg::word_t a, exec_pkg::word_t b);
        logic [32:0] w32;
        logic [64:0] w64;
        if (t.op == exec_pkg::op_add) begin
            w32 = {a[31], a[31:0]} + {b[31], b[31:0]};
            w64 = {a[63], a} + {b[63], b};
        end else if (t.op == exec_pkg::op_sub) begin
            w32 = {a[31], a[31:0]} - {b[31], b[31:0]};
            w64 = {a[63], a} - {b[63], b};
        end else begin
            return 1'b0;
        end
        return t.word ? (w32[32] != w32[31]) : (w64[64] != w64[63]);
    endfunction

    task automatic add_test(string name, exec_pkg::op_t op_v, logic word_v, exec_pkg::fwd_t fa,
            exec_pkg::fwd_t fb, exec_pkg::word_t ra, exec_pkg::word_t rb, exec_pkg::word_t md,
            exec_pkg::shamt_t sh, exec_pkg::imm_t iv, exec_pkg::word_t er, logic eo);
        test_t t;
        t = '{name, op_v, word_v, fa, fb, ra, rb, md, sh, iv, er, eo};
        tests.push_back(t);
    endtask

    task automatic build_directed_tests();
        // arithmetic, overflow at 64 and 32 bits
        add_test("add_ovf64", exec_pkg::op_add, 1'b0, fr, fr, 64'h7fff_ffff_ffff_ffff,
            64'h1, 64'h0, 6'd0, 16'h0, 64'h8000_0000_0000_0000, 1'b1);
        add_test("sub_ovf64", exec_pkg::op_sub, 1'b0, fr, fr, 64'h8000_0000_0000_0000,
            64'h1, 64'h0, 6'd0, 16'h0, 64'h7fff_ffff_ffff_ffff, 1'b1);
        add_test("addw_ovf32", exec_pkg::op_add, 1'b1, fr, fr, 64'h0000_0000_7fff_ffff,
            64'h1, 64'h0, 6'd0, 16'h0, 64'hffff_ffff_8000_0000, 1'b1);
        add_test("subw_wrap", exec_pkg::op_sub, 1'b1, fr, fr, 64'h1234_5678_0000_0000,
            64'h1, 64'h0, 6'd0, 16'h0, 64'hffff_ffff_ffff_ffff, 1'b0);
        add_test("and_no_ovf", exec_pkg::op_and, 1'b0, fr, fr, 64'h7fff_ffff_ffff_ffff,
            64'h1, 64'h0, 6'd0, 16'h0, 64'h1, 1'b0);
        // compares
        add_test("slt_mixed", exec_pkg::op_slt, 1'b0, fr, fr, 64'hffff_ffff_ffff_ffff,
            64'h1, 64'h0, 6'd0, 16'h0, 64'h1, 1'b0);
        add_test("sltu_mixed", exec_pkg::op_sltu, 1'b0, fr, fr, 64'hffff_ffff_ffff_ffff,
            64'h1, 64'h0, 6'd0, 16'h0, 64'h0, 1'b0);
        add_test("slt_neg", exec_pkg::op_slt, 1'b0, fr, fr, 64'hffff_ffff_ffff_fffe,
            64'hffff_ffff_ffff_ffff, 64'h0, 6'd0, 16'h0, 64'h1, 1'b0);
        add_test("slt_equal", exec_pkg::op_slt, 1'b0, fr, fr, 64'h8000_0000_0000_0000,
            64'h8000_0000_0000_0000, 64'h0, 6'd0, 16'h0, 64'h0, 1'b0);
        add_test("sltu_same", exec_pkg::op_sltu, 1'b0, fr, fr, 64'hffff_ffff_ffff_fffe,
            64'hffff_ffff_ffff_ffff, 64'h0, 6'd0, 16'h0, 64'h1, 1'b0);
        add_test("sltu_equal", exec_pkg::op_sltu, 1'b0, fr, fr, 64'h8000_0000_0000_0000,
            64'h8000_0000_0000_0000, 64'h0, 6'd0, 16'h0, 64'h0, 1'b0);
        // bitwise on patterns
        add_test("or_pattern", exec_pkg::op_or, 1'b0, fr, fr, 64'hf0f0_f0f0_f0f0_f0f0,
            64'h0ff0_0ff0_0ff0_0ff0, 64'h0, 6'd0, 16'h0, 64'hfff0_fff0_fff0_fff0, 1'b0);
        add_test("xor_pattern", exec_pkg::op_xor, 1'b0, fr, fr, 64'hf0f0_f0f0_f0f0_f0f0,
            64'h0ff0_0ff0_0ff0_0ff0, 64'h0, 6'd0, 16'h0, 64'hff00_ff00_ff00_ff00, 1'b0);
        add_test("nor_pattern", exec_pkg::op_nor, 1'b0, fr, fr, 64'hf0f0_f0f0_f0f0_f0f0,
            64'h0ff0_0ff0_0ff0_0ff0, 64'h0, 6'd0, 16'h0, 64'h000f_000f_000f_000f, 1'b0);
        // shifts act on operand b
        add_test("sll_0", exec_pkg::op_sll, 1'b0, fr, fr, 64'h0,
            64'h8000_0000_0000_0001, 64'h0, 6'd0, 16'h0, 64'h8000_0000_0000_0001, 1'b0);
        add_test("sll_63", exec_pkg::op_sll, 1'b0, fr, fr, 64'h0,
            64'h1, 64'h0, 6'd63, 16'h0, 64'h8000_0000_0000_0000, 1'b0);
        add_test("srl_32", exec_pkg::op_srl, 1'b0, fr, fr, 64'h0,
            64'h8000_0000_0000_0000, 64'h0, 6'd32, 16'h0, 64'h0000_0000_8000_0000, 1'b0);
        add_test("sra_31", exec_pkg::op_sra, 1'b0, fr, fr, 64'h0,
            64'h8000_0000_0000_0000, 64'h0, 6'd31, 16'h0, 64'hffff_ffff_0000_0000, 1'b0);
        add_test("sllw_31", exec_pkg::op_sll, 1'b1, fr, fr, 64'h0,
            64'hffff_ffff_0000_0001, 64'h0, 6'd31, 16'h0, 64'hffff_ffff_8000_0000, 1'b0);
        add_test("sraw_4", exec_pkg::op_sra, 1'b1, fr, fr, 64'h0,
            64'h0000_0000_8000_0000, 64'h0, 6'd4, 16'h0, 64'hffff_ffff_f800_0000, 1'b0);
        add_test("lui_pos", exec_pkg::op_lui, 1'b0, fr, fr, 64'h0,
            64'h0, 64'h0, 6'd0, 16'h1234, 64'h0000_0000_1234_0000, 1'b0);
        add_test("lui_neg", exec_pkg::op_lui, 1'b0, fr, fr, 64'h0,
            64'h0, 64'h0, 6'd0, 16'h8001, 64'hffff_ffff_8001_0000, 1'b0);
        // reg values here are wrong on purpose
        add_test("fwd_ex_a", exec_pkg::op_add, 1'b0, fe, fr, 64'hdead,
            64'h1, 64'h0, 6'd0, 16'h0, 64'hffff_ffff_8001_0001, 1'b0);
        add_test("fwd_mem_b", exec_pkg::op_sub, 1'b0, fr, fm, 64'h100,
            64'hdead, 64'h1, 6'd0, 16'h0, 64'hff, 1'b0);
        add_test("fwd_mem_a_ex_b", exec_pkg::op_add, 1'b0, fm, fe, 64'hdead,
            64'hdead, 64'h1000, 6'd0, 16'h0, 64'h10ff, 1'b0);
    endtask

    task automatic build_random_tests();
        test_t           t;
        exec_pkg::word_t prev;
        exec_pkg::word_t a;
        exec_pkg::word_t b;
        rng_state = 64'd88690;
        prev = tests[tests.size() - 1].exp_result;
        for (int i = 0; i < 40; i++) begin
            t.name     = $sformatf("random_%0d", i);
            t.op       = exec_pkg::op_t'(4'(next_random() % 12));
            t.word     = 1'(next_random());
            t.fwd_a    = exec_pkg::fwd_t'(2'(next_random() % 3));
            t.fwd_b    = exec_pkg::fwd_t'(2'(next_random() % 3));
            t.reg_a    = next_random();
            t.reg_b    = next_random();
            t.mem_data = next_random();
            t.shamt    = 6'(next_random());
            t.imm      = 16'(next_random());
            a = source_operand(t.fwd_a, t.reg_a, prev, t.mem_data);
            b = source_operand(t.fwd_b, t.reg_b, prev, t.mem_data);
            t.exp_result   = model_result(t, a, b);
            t.exp_overflow = model_overflow(t, a, b);
            tests.push_back(t);
            prev = t.exp_result;
        end
    endtask

    task automatic check_word(string name, exec_pkg::word_t expected, exec_pkg::word_t actual);
        if (actual !== expected) begin
            $display("FAILED %s result expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_flag(string name, logic expected, logic actual);
        if (actual !== expected) begin
            $display("FAILED %s overflow expected %b actual %b", name, expected, actual);
            errors++;
        end
    endtask

    task automatic run_test(test_t t, int index);
        int              wait_cycles;
        int              errors_before;
        exec_pkg::word_t held;
        errors_before = errors;
        @(negedge clock);
        op       = t.op;
        word     = t.word;
        fwd_a    = t.fwd_a;
        fwd_b    = t.fwd_b;
        reg_a    = t.reg_a;
        reg_b    = t.reg_b;
        mem_data = t.mem_data;
        shamt    = t.shamt;
        imm      = t.imm;
        req      = 1'b1;
        wait_cycles = 0;
        do begin
            @(negedge clock);
            wait_cycles++;
        end while (!ack && wait_cycles < 10);
        if (!ack) begin
            $display("no acknowledge for test %s", t.name);
            errors++;
        end else begin
            check_word(t.name, t.exp_result, result);
            check_flag(t.name, t.exp_overflow, overflow);
            // back-pressure on every eighth test
            if (index % 8 == 0) begin
                held = result;
                repeat (5) begin
                    @(negedge clock);
                    if (!ack || result !== held) begin
                        $display("result not held under back-pressure in test %s", t.name);
                        errors++;
                    end
                end
            end
        end
        req = 1'b0;
        wait_cycles = 0;
        while (ack && wait_cycles < 10) begin
            @(negedge clock);
            wait_cycles++;
        end
        if (ack) begin
            $display("ack did not drop after req fell in test %s", t.name);
            errors++;
        end
        if (errors == errors_before) begin
            $display("ok      %s", t.name);
            passed++;
        end
    endtask

    task automatic stop_on_timeout(int cycles);
        repeat (cycles) @(posedge clock);
        $display("run did not finish within %0d clock cycles", cycles);
        $display("Simulation FAILED");
        $finish;
    endtask

    initial begin
        req      = 1'b0;
        op       = exec_pkg::op_add;
        word     = 1'b0;
        fwd_a    = fr;
        fwd_b    = fr;
        reg_a    = '0;
        reg_b    = '0;
        mem_data = '0;
        shamt    = '0;
        imm      = '0;
        errors   = 0;
        passed   = 0;
        build_directed_tests();
        build_random_tests();
        fork
            stop_on_timeout(tests.size() * 8 + 20);
        join_none
        wait (reset === 1'b0);
        foreach (tests[i]) begin
            run_test(tests[i], i);
        end
        errors += int'(u_exec_unit.u_chk.error_count);
        $display("%0d tests, %0d ok, %0d errors", tests.size(), passed, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- exec_unit.f
logic/exec_pkg.sv
logic/exec_control.sv
logic/arith_unit.sv
logic/logic_unit.sv
logic/shift_unit.sv
logic/result_select.sv
logic/exec_unit.sv
dv/clock_gen.sv
dv/exec_unit_chk.sv
dv/exec_unit_tb.sv
